/* coreMemSubsystem.f */
rtl/coreMemPkg.sv
rtl/coreMemBus.sv
rtl/coreMemController.sv
rtl/unifiedMemory.sv
rtl/coreReadReturn.sv
rtl/coreMemSubsystem.sv
dv/coreMemSubsystemTb.sv

/* Makefile */
# Verilator build, lint and clean for the core memory subsystem.
# The run exits with a failing status when the testbench stops on $fatal.

TOP := coreMemSubsystemTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): coreMemSubsystem.f $(wildcard rtl/*.sv) dv/coreMemSubsystemTb.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f coreMemSubsystem.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f coreMemSubsystem.f

clean:
	rm -rf obj_dir

/* dv/coreMemGolden.txt */
// Columns: kind addr data expected, all hex, one entry per line.
// Kinds: 0 preload instruction word (data is the word), 1 fetch, 2 read, 3 write, 4 swap, f end.
0 0000 1a2b 0000
0 0001 3c4d 0000
0 0010 5e6f 0000
0 0123 7788 0000
0 7fff 9abc 0000
// Fetches of preloaded words right after reset.
1 0000 0000 1a2b
1 0001 0000 3c4d
// Write then read back.
3 0010 beef 0000
2 0010 0000 beef
// Same word address in the instruction region is untouched.
1 0010 0000 5e6f
3 0123 cafe 0000
3 0124 0f0f 0000
2 0124 0000 0f0f
2 0123 0000 cafe
// Swap returns the old word and stores the new one.
4 0123 1357 cafe
2 0123 0000 1357
1 0123 0000 7788
// Back to back swaps on the top address.
3 7fff 2468 0000
4 7fff 8642 2468
4 7fff 0001 8642
2 7fff 0000 0001
1 7fff 0000 9abc
1 0000 0000 1a2b
2 0010 0000 beef
f 0000 0000 0000

/* dv/coreMemSubsystemTb.sv */
// Testbench for the core local memory subsystem.
// Reads preload words and operations from the golden data file, loads the
// instruction region by backdoor, then drives fetches, reads, writes and
// swaps through the core ports and checks status timing and returned words.

`timescale 1ns/1ps

module coreMemSubsystemTb;
    import coreMemPkg::*;

    // Golden file layout of four words per line.
    localparam int MaxLines = 64;
    localparam memWord_t KindPreload = 16'h0;
    localparam memWord_t KindFetch   = 16'h1;
    localparam memWord_t KindRead    = 16'h2;
    localparam memWord_t KindWrite   = 16'h3;
    localparam memWord_t KindSwap    = 16'h4;
    localparam memWord_t KindEnd     = 16'hf;

    logic      clk = 1'b0;
    logic      rstN;
    wordAddr_t iAddr;
    wordAddr_t dAddr;
    memWord_t  dData;
    logic      dWr;
    logic      dSwp;
    logic      dEn;
    logic      iIsBusy;
    memWord_t  iData;
    logic      iValid;
    logic      dIsReading;
    logic      dIsDone;
    memWord_t  dRdData;
    logic      dRdValid;

    memWord_t  golden [MaxLines*4];
    integer    seed;
    int        gap;
    int        lineIdx;
    int        base;
    int        lineCount;
    int        opCount;
    logic      endFound;
    logic      goldenLoaded = 1'b0;
    memWord_t  kind;

    // 20 ns period.
    always #10 clk = ~clk;

    coreMemSubsystem #(.AddrWidth(AddrWidth)) u_dut (
        .i_clk        (clk),
        .i_rstN       (rstN),
        .i_iAddr      (iAddr),
        .o_iIsBusy    (iIsBusy),
        .o_iData      (iData),
        .o_iValid     (iValid),
        .i_dAddr      (dAddr),
        .i_dData      (dData),
        .i_dWr        (dWr),
        .i_dSwp       (dSwp),
        .i_dEn        (dEn),
        .o_dIsReading (dIsReading),
        .o_dIsDone    (dIsDone),
        .o_dRdData    (dRdData),
        .o_dRdValid   (dRdValid)
    );

    // --------------------
    // Checks.
    // --------------------

    task automatic compareWord(input string name, input memWord_t got, input memWord_t expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "flag mismatch on %s", name);
        end
    endtask

    // --------------------
    // Operations.
    // --------------------
    // Each one starts and ends at a falling edge.

    // Word of the fetch cycle shows up one cycle later.
    task automatic fetchWord(input wordAddr_t addr, input memWord_t expected);
        @(posedge clk);
        iAddr <= addr;
        @(posedge clk);
        @(negedge clk);
        compareFlag("o_iValid", iValid, 1'b1);
        compareWord("o_iData", iData, expected);
    endtask

    // One write cycle with done raised together with busy.
    task automatic writeWord(input wordAddr_t addr, input memWord_t data);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
        @(posedge clk);
        dAddr <= addr;
        dData <= data;
        dWr   <= 1'b1;
        dEn   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compareFlag("o_dIsDone", dIsDone, 1'b1);
        compareFlag("o_iIsBusy", iIsBusy, 1'b1);
        compareFlag("o_dIsReading", dIsReading, 1'b0);
        @(posedge clk);
        dEn <= 1'b0;
        dWr <= 1'b0;
        @(negedge clk);
        compareFlag("o_dIsDone", dIsDone, 1'b0);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
    endtask

    // Reading and done rise together and the word follows one cycle later.
    task automatic readWord(input wordAddr_t addr, input memWord_t expected);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
        @(posedge clk);
        dAddr <= addr;
        dEn   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compareFlag("o_dIsReading", dIsReading, 1'b1);
        compareFlag("o_dIsDone", dIsDone, 1'b1);
        compareFlag("o_iIsBusy", iIsBusy, 1'b1);
        compareFlag("o_dRdValid", dRdValid, 1'b0);
        @(posedge clk);
        dEn <= 1'b0;
        @(negedge clk);
        compareFlag("o_dRdValid", dRdValid, 1'b1);
        compareWord("o_dRdData", dRdData, expected);
        compareFlag("o_dIsReading", dIsReading, 1'b0);
        compareFlag("o_dIsDone", dIsDone, 1'b0);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
    endtask

    // Old word returns in the done cycle.
    task automatic swapWord(input wordAddr_t addr, input memWord_t data, input memWord_t expected);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
        @(posedge clk);
        dAddr <= addr;
        dData <= data;
        dSwp  <= 1'b1;
        dEn   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compareFlag("o_dIsReading", dIsReading, 1'b1);
        compareFlag("o_dIsDone", dIsDone, 1'b0);
        compareFlag("o_iIsBusy", iIsBusy, 1'b1);
        @(posedge clk);
        @(negedge clk);
        compareFlag("o_dIsDone", dIsDone, 1'b1);
        compareFlag("o_dIsReading", dIsReading, 1'b0);
        compareFlag("o_dRdValid", dRdValid, 1'b1);
        compareWord("o_dRdData", dRdData, expected);
        @(posedge clk);
        dEn  <= 1'b0;
        dSwp <= 1'b0;
        @(negedge clk);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
    endtask

    // --------------------
    // Watchdog.
    // --------------------

    initial begin
        wait (goldenLoaded);
        repeat (opCount * 40 + 100) @(posedge clk);
        $display("Watchdog timeout, run did not finish in %0d cycles", opCount * 40 + 100);
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    // --------------------
    // Main sequence.
    // --------------------

    initial begin
        rstN  = 1'b0;
        iAddr = '0;
        dAddr = '0;
        dData = '0;
        dWr   = 1'b0;
        dSwp  = 1'b0;
        dEn   = 1'b0;
        seed  = 32'h8cf1_9251;
        $readmemh("dv/coreMemGolden.txt", golden);

        // Find the end marker and count the timed operations.
        endFound  = 1'b0;
        lineCount = 0;
        opCount   = 0;
        for (int i = 0; i < MaxLines; i++) begin
            if (!endFound) begin
                if (golden[4*i] == KindEnd) begin
                    endFound  = 1'b1;
                    lineCount = i;
                end else if (golden[4*i] != KindPreload) begin
                    opCount++;
                end
            end
        end
        if (!endFound) begin
            $display("Golden file has no end marker within %0d lines", MaxLines);
            $display("Simulation FAILED");
            $fatal(1, "bad golden file");
        end

        // Instruction region is the lower half of the array.
        for (int i = 0; i < lineCount; i++) begin
            if (golden[4*i] == KindPreload) begin
                u_dut.u_memory.mem[{1'b0, wordAddr_t'(golden[4*i+1])}] = golden[4*i+2];
            end
        end
        goldenLoaded = 1'b1;

        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compareFlag("o_iIsBusy", iIsBusy, 1'b0);
        compareFlag("o_dIsReading", dIsReading, 1'b0);
        compareFlag("o_dIsDone", dIsDone, 1'b0);
        compareFlag("o_iValid", iValid, 1'b0);
        compareFlag("o_dRdValid", dRdValid, 1'b0);

        for (lineIdx = 0; lineIdx < lineCount; lineIdx++) begin
            base = 4 * lineIdx;
            kind = golden[base];
            if (kind != KindPreload) begin
                case (kind)
                    KindFetch: fetchWord(wordAddr_t'(golden[base+1]), golden[base+3]);
                    KindRead:  readWord(wordAddr_t'(golden[base+1]), golden[base+3]);
                    KindWrite: writeWord(wordAddr_t'(golden[base+1]), golden[base+2]);
                    KindSwap: begin
                        swapWord(wordAddr_t'(golden[base+1]), golden[base+2], golden[base+3]);
                    end
                    default: begin
                        $display("Unknown operation kind %h on golden line %0d", kind, lineIdx);
                        $display("Simulation FAILED");
                        $fatal(1, "bad golden file");
                    end
                endcase
                // Idle fetch cycles between operations.
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* rtl/coreMemSubsystem.sv */
// Top level of the core local memory subsystem.
// Joins the decode, storage and result stages through one bus.
// The core drives the plain ports below and reads back fetched
// instruction words, data read words and the status levels.

`timescale 1ns/1ps

module coreMemSubsystem #(
    parameter int AddrWidth = coreMemPkg::AddrWidth
) (
    input  logic                  i_clk,
    input  logic                  i_rstN,

    // Instruction side.
    input  coreMemPkg::wordAddr_t i_iAddr,
    output logic                  o_iIsBusy,
    output coreMemPkg::memWord_t  o_iData,
    output logic                  o_iValid,

    // Data side.
    input  coreMemPkg::wordAddr_t i_dAddr,
    input  coreMemPkg::memWord_t  i_dData,
    input  logic                  i_dWr,
    input  logic                  i_dSwp,
    input  logic                  i_dEn,
    output logic                  o_dIsReading,
    output logic                  o_dIsDone,
    output coreMemPkg::memWord_t  o_dRdData,
    output logic                  o_dRdValid
);

    // --------------------
    // Stages.
    // --------------------

    coreMemBus #(.AddrWidth(AddrWidth)) u_bus ();

    // Decode.
    coreMemController #(.AddrWidth(AddrWidth)) u_controller (
        .i_clk        (i_clk),
        .i_rstN       (i_rstN),
        .i_iAddr      (i_iAddr),
        .o_iIsBusy    (o_iIsBusy),
        .i_dAddr      (i_dAddr),
        .i_dData      (i_dData),
        .i_dWr        (i_dWr),
        .i_dSwp       (i_dSwp),
        .i_dEn        (i_dEn),
        .o_dIsReading (o_dIsReading),
        .o_dIsDone    (o_dIsDone),
        .bus          (u_bus)
    );

    // Storage.
    unifiedMemory #(.AddrWidth(AddrWidth)) u_memory (
        .i_clk (i_clk),
        .bus   (u_bus)
    );

    // Result.
    coreReadReturn u_return (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .bus        (u_bus),
        .o_iData    (o_iData),
        .o_iValid   (o_iValid),
        .o_dRdData  (o_dRdData),
        .o_dRdValid (o_dRdValid)
    );

endmodule

/* rtl/coreReadReturn.sv */
// Result stage of the core memory subsystem.
// Registers the word read in each instruction fetch cycle and in each
// data read or swap read cycle. Each word comes with a one cycle valid.

`timescale 1ns/1ps

module coreReadReturn (
    input  logic                 i_clk,
    input  logic                 i_rstN,

    coreMemBus.ret               bus,

    // Fetched instruction word.
    output coreMemPkg::memWord_t o_iData,
    output logic                 o_iValid,

    // Data read word, also the old word of a swap.
    output coreMemPkg::memWord_t o_dRdData,
    output logic                 o_dRdValid
);
    import coreMemPkg::*;

    logic isFetch;
    logic isDataRead;

    assign isFetch    = (bus.state == StIRead);
    // Swap read returns the old value like a plain read.
    assign isDataRead = (bus.state == StDRead) || (bus.state == StSwapRead);

    // --------------------
    // Valid pulses.
    // --------------------

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_iValid   <= 1'b0;
            o_dRdValid <= 1'b0;
        end else begin
            o_iValid   <= isFetch;
            o_dRdValid <= isDataRead;
        end
    end

    // Words hold until the next matching cycle.
    always_ff @(posedge i_clk) begin
        if (isFetch) begin
            o_iData <= bus.rdData;
        end
        if (isDataRead) begin
            o_dRdData <= bus.rdData;
        end
    end

    // One state per cycle, so the two valids never overlap.
    validOverlapCheck: assert property (@(posedge i_clk) disable iff (!i_rstN)
        !(o_iValid && o_dRdValid))
        else $error("instruction and data valid together");

endmodule

/* rtl/unifiedMemory.sv */
// Storage array of the core memory subsystem.
// Two regions of equal size in one array, selected by the top address
// bit. Reads are asynchronous, writes happen on the clock when wr is high.
// There is no reset; the instruction region is loaded from outside.

`timescale 1ns/1ps

module unifiedMemory #(
    parameter int AddrWidth = coreMemPkg::AddrWidth
) (
    input  logic    i_clk,
    coreMemBus.mem  bus
);
    import coreMemPkg::*;

    // Both regions together.
    localparam int Depth = 2 ** (AddrWidth + 1);

    // --------------------
    // Array.
    // --------------------

    // Lower half holds instructions, upper half holds data.
    memWord_t mem [Depth];

    // Read path, valid within the cycle.
    assign bus.rdData = mem[bus.addr];

    // Write path.
    always_ff @(posedge i_clk) begin
        if (bus.wr) begin
            mem[bus.addr] <= bus.wrData;
        end
    end

    // --------------------
    // Checks.
    // --------------------

    // The controller only writes with the data region bit set.
    dataRegionCheck: assert property (@(posedge i_clk)
        bus.wr |-> bus.addr[AddrWidth])
        else $error("write into instruction region at %h", bus.addr);

endmodule

/* rtl/coreMemController.sv */
// Decode stage of the core memory subsystem.
// Interleaves instruction fetches with data reads, writes and swaps on one
// unified memory. Instruction read is the resting state. The core holds
// its data inputs until o_dIsDone and watches o_iIsBusy before a request.

`timescale 1ns/1ps

module coreMemController #(
    parameter int AddrWidth = coreMemPkg::AddrWidth
) (
    input  logic                  i_clk,
    input  logic                  i_rstN,

    // Instruction side, read is implied.
    input  coreMemPkg::wordAddr_t i_iAddr,
    output logic                  o_iIsBusy,

    // Data side requests.
    input  coreMemPkg::wordAddr_t i_dAddr,
    input  coreMemPkg::memWord_t  i_dData,
    input  logic                  i_dWr,
    input  logic                  i_dSwp,
    input  logic                  i_dEn,

    // Data side status.
    output logic                  o_dIsReading,
    output logic                  o_dIsDone,

    coreMemBus.ctrl               bus
);
    import coreMemPkg::*;

    memState_t            state;
    memState_t            stateNext;
    // Address and data buffers, loaded every cycle.
    logic [AddrWidth-1:0] addrBuf;
    memWord_t             dataBuf;
    // High in every data state.
    logic                 servingData;
    logic [AddrWidth-1:0] wordAddr;

    // --------------------
    // State machine.
    // --------------------

    always_comb begin
        stateNext = StIRead;
        case (state)
            StIRead: begin
                // Write, swap or read, in that order of decode.
                if (i_dEn && i_dWr && !i_dSwp) begin
                    stateNext = StDWrite;
                end else if (i_dEn && !i_dWr && i_dSwp) begin
                    stateNext = StSwapRead;
                end else if (i_dEn && !i_dWr && !i_dSwp) begin
                    stateNext = StDRead;
                end
            end
            // Second swap cycle writes the new value.
            StSwapRead: stateNext = StDWrite;
            default:    stateNext = StIRead;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            state <= StIRead;
        end else begin
            state <= stateNext;
        end
    end

    // Buffers keep the swap address and data steady across both cycles.
    always_ff @(posedge i_clk) begin
        addrBuf <= AddrWidth'(i_dAddr);
        dataBuf <= i_dData;
    end

    // --------------------
    // Bus drive.
    // --------------------

    assign servingData = (state != StIRead);

    // Data states use the buffered address.
    assign wordAddr = servingData ? addrBuf : AddrWidth'(i_iAddr);

    // Region bit selects the data half.
    assign bus.addr   = {servingData, wordAddr};
    assign bus.wrData = dataBuf;
    // Instructions are never written.
    assign bus.wr     = (state == StDWrite);
    assign bus.state  = state;

    // --------------------
    // Status.
    // --------------------

    assign o_iIsBusy    = servingData;
    assign o_dIsReading = (state == StSwapRead) || (state == StDRead);
    // Last cycle of every data access.
    assign o_dIsDone    = (state == StDWrite) || (state == StDRead);

    // A request names one access kind only.
    oneKindCheck: assert property (@(posedge i_clk) disable iff (!i_rstN)
        (state == StIRead && i_dEn) |-> !(i_dWr && i_dSwp))
        else $error("write and swap requested together");

    // Core holds the address until the access is done.
    addrHoldCheck: assert property (@(posedge i_clk) disable iff (!i_rstN)
        (state != StIRead) |-> $stable(i_dAddr))
        else $error("data address changed before done");

endmodule

/* rtl/coreMemBus.sv */
// Bus between the memory controller, the unified memory and the result
// stage. Carries the unified address, separate write and read data, the
// write strobe and the controller state.

`timescale 1ns/1ps

interface coreMemBus #(
    parameter int AddrWidth = coreMemPkg::AddrWidth
);
    import coreMemPkg::*;

    // Region bit followed by the word address.
    logic [AddrWidth:0] addr;
    // Buffered write data from the controller.
    memWord_t           wrData;
    // Write strobe, high only in the data write state.
    logic               wr;
    // Current controller state, used by the result stage.
    memState_t          state;
    // Raw word at addr, valid within the cycle.
    memWord_t           rdData;

    // Controller side.
    modport ctrl (output addr, output wrData, output wr, output state);

    // Storage array side.
    modport mem (input addr, input wrData, input wr, output rdData);

    // Result stage side.
    modport ret (input state, input rdData);

endinterface

/* rtl/coreMemPkg.sv */
// Shared types for the core local memory subsystem.
// Holds the word and address widths, the typedefs that carry them and
// the controller state encoding. Modules import it inside their bodies.

package coreMemPkg;

    // --------------------
    // Widths.
    // --------------------

    // One data or instruction word.
    localparam int WordWidth = 16;
    // Word address inside one region.
    localparam int AddrWidth = 15;

    // --------------------
    // Types.
    // --------------------

    typedef logic [WordWidth-1:0] memWord_t;
    typedef logic [AddrWidth-1:0] wordAddr_t;
    // Region bit on top of the region word address.
    typedef logic [AddrWidth:0] coreAddr_t;

    // Two bit encoding of the controller states.
    typedef enum logic [1:0] {
        StIRead    = 2'b00,
        StDWrite   = 2'b01,
        StSwapRead = 2'b10,
        StDRead    = 2'b11
    } memState_t;

endpackage
